// ==== msx_io.f ====
+incdir+source
source/msx_pkg.sv
source/io_control.sv
source/vdp_port.sv
source/vdp_status.sv
source/ppi_port.sv
source/bus_read_mux.sv
source/msx_io.sv
sim/msx_io_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f msx_io.f --top-module msx_io_tb -o msx_io_sim
./obj_dir/msx_io_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== sim/msx_io_tb.sv ====
`default_nettype none

`include "msx_defines.svh"

module msx_io_tb import msx_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 4 * `MSX_CLK_DIV; // Cycles before a wait gives up

  localparam logic [2:0] OP_IOWR  = 3'd0;
  localparam logic [2:0] OP_IORD  = 3'd1;
  localparam logic [2:0] OP_MEMRD = 3'd2;
  localparam logic [2:0] OP_MEMWR = 3'd3;
  localparam logic [2:0] OP_FLAG  = 3'd4;        // Drive the VDP flag inputs

  localparam logic [3:0] CHK_NONE     = 4'd0;
  localparam logic [3:0] CHK_DIN      = 4'd1;
  localparam logic [3:0] CHK_PORT_A   = 4'd2;
  localparam logic [3:0] CHK_PORT_C   = 4'd3;
  localparam logic [3:0] CHK_MODE     = 4'd4;
  localparam logic [3:0] CHK_VADDR    = 4'd5;
  localparam logic [3:0] CHK_RAM_WE   = 4'd6;
  localparam logic [3:0] CHK_PSG      = 4'd7;
  localparam logic [3:0] CHK_NAME     = 4'd8;
  localparam logic [3:0] CHK_COLOR    = 4'd9;
  localparam logic [3:0] CHK_PATTERN  = 4'd10;
  localparam logic [3:0] CHK_SPR_ATTR = 4'd11;
  localparam logic [3:0] CHK_SPR_PAT  = 4'd12;
  localparam logic [3:0] CHK_DISP_COL = 4'd13; // Display enable, text and back colour

  localparam cpu_bus_t BUS_IDLE = '{addr: 16'h0000, data: 8'h00, n_rd: 1'b1,
                                    n_wr: 1'b1, n_mreq: 1'b1, n_iorq: 1'b1};

  typedef struct packed {
    logic [2:0]  op;
    logic [3:0]  chk;     // Which output the row compares
    logic        rom_p1;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [15:0] exp_val;
  } row_t;

  logic                    cpuClock;
  logic                    n_hard_reset;
  cpu_bus_t                i_bus;
  logic [7:0]              i_port_b;
  logic [7:0]              i_vram_dout;
  logic                    i_interrupt_flag;
  logic                    i_sprite_collision;
  logic                    i_too_many_sprites;
  logic [4:0]              i_sprite5;
  logic [5:0]              i_joystick;
  logic [7:0]              i_ram_dout;
  logic [7:0]              i_rom_dout;
  logic                    i_rom_page1;
  logic                    o_cpu_clk_en;
  logic [7:0]              o_cpu_din;
  logic                    o_ram_we;
  logic [`MSX_VRAM_AW-1:0] o_vram_addr;
  logic                    o_vram_wr;
  vdp_view_t               o_view;
  logic [1:0]              o_mode;
  logic [3:0]              o_psg_reg;
  logic [7:0]              o_port_a;
  logic [7:0]              o_port_c;

  logic [31:0] seed_init;
  logic [7:0]  vdp_wdata;
  int          en_high;
  int          en_low;
  string       names[$];
  row_t        rows[$];

  msx_io u_msx_io (
    .cpuClock, .n_hard_reset, .i_bus, .i_port_b, .i_vram_dout,
    .i_interrupt_flag, .i_sprite_collision, .i_too_many_sprites, .i_sprite5,
    .i_joystick, .i_ram_dout, .i_rom_dout, .i_rom_page1,
    .o_cpu_clk_en, .o_cpu_din, .o_ram_we, .o_vram_addr, .o_vram_wr,
    .o_view, .o_mode, .o_psg_reg, .o_port_a, .o_port_c
  );

  always #4 cpuClock = ~cpuClock;

  // ============================================================
  // Helpers
  // ============================================================
  task automatic check_value(input string name, input logic [15:0] exp_val,
                             input logic [15:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
      $display("Test FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Sampled just after the rising clock edge
  task automatic wait_enable(input logic level);
    int cycles;
    cycles = 0;
    while (o_cpu_clk_en !== level) begin
      @(posedge cpuClock);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("The CPU clock enable never reached level %0b", level);
        $display("Test FAILED");
        $fatal(1, "Clock enable timeout");
      end
    end
  endtask

  // Counts the cycles that the clock enable stays at one level
  task automatic measure_enable(input logic level, output int cycles);
    cycles = 0;
    while (o_cpu_clk_en === level) begin
      @(posedge cpuClock);
      #1;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("The CPU clock enable stayed at level %0b too long", level);
        $display("Test FAILED");
        $fatal(1, "Clock enable stuck");
      end
    end
  endtask

  task automatic add_row(input string name, input logic [2:0] op, input logic [15:0] addr,
                         input logic [7:0] data, input logic [3:0] chk,
                         input logic [15:0] exp_val, input logic rom_p1);
    row_t r;
    r = '{op: op, chk: chk, rom_p1: rom_p1, addr: addr, data: data, exp_val: exp_val};
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic run_row(input string name, input row_t r);
    logic [15:0] actual;
    logic        exp_wr;
    actual = 16'h0000;
    exp_wr = r.op == OP_IOWR && r.addr[7:0] == `MSX_VDP_DATA_PORT;
    wait_enable(1'b0);                        // Start in a low phase, no edge pending
    i_rom_page1 = r.rom_p1;
    if (r.op == OP_FLAG) begin
      i_too_many_sprites = r.data[2];         // Levels, held until the next flag row
      i_sprite5          = r.data[7:3];
      i_interrupt_flag   = r.data[0];
      i_sprite_collision = r.data[1];
      @(posedge cpuClock);
      #1;
      i_interrupt_flag   = 1'b0;
      i_sprite_collision = 1'b0;
      @(posedge cpuClock);
      #1;
    end else begin
      i_bus.addr   = r.addr;
      i_bus.data   = r.data;
      i_bus.n_rd   = !(r.op == OP_IORD || r.op == OP_MEMRD);
      i_bus.n_wr   = !(r.op == OP_IOWR || r.op == OP_MEMWR);
      i_bus.n_iorq = !(r.op == OP_IORD || r.op == OP_IOWR);
      i_bus.n_mreq = !(r.op == OP_MEMRD || r.op == OP_MEMWR);
      wait_enable(1'b1);
      // VRAM write pulses in the enable edge cycle only for data port writes
      check_value($sformatf("%s vram_wr", name), {15'd0, exp_wr}, {15'd0, o_vram_wr});
      @(posedge cpuClock);                    // Held one more cycle, effect now visible
      #1;
      case (r.chk)
        CHK_DIN:      actual = {8'h00, o_cpu_din};
        CHK_PORT_A:   actual = {8'h00, o_port_a};
        CHK_PORT_C:   actual = {8'h00, o_port_c};
        CHK_MODE:     actual = {14'd0, o_mode};
        CHK_VADDR:    actual = {2'b00, o_vram_addr};
        CHK_RAM_WE:   actual = {15'd0, o_ram_we};
        CHK_PSG:      actual = {12'd0, o_psg_reg};
        CHK_NAME:     actual = {2'b00, o_view.name_base};
        CHK_COLOR:    actual = {2'b00, o_view.color_base};
        CHK_PATTERN:  actual = {2'b00, o_view.pattern_base};
        CHK_SPR_ATTR: actual = {2'b00, o_view.sprite_attr_base};
        CHK_SPR_PAT:  actual = {2'b00, o_view.sprite_pattern_base};
        CHK_DISP_COL: actual = {7'd0, o_view.display_en, o_view.text_color,
                                o_view.back_color};
        default:      actual = 16'h0000;
      endcase
      if (r.chk != CHK_NONE) check_value(name, r.exp_val, actual);
      // Idle across one more enable edge so end-of-read strobes fire
      i_bus = BUS_IDLE;
      wait_enable(1'b0);
      wait_enable(1'b1);
      @(posedge cpuClock);
      #1;
    end
  endtask

  // ============================================================
  // Stimulus table
  // ============================================================
  task automatic build_table();
    add_row("ppi_a_write", OP_IOWR, 16'h00A8, 8'h5A, CHK_PORT_A, 16'h005A, 1'b0);
    add_row("ppi_a_read", OP_IORD, 16'h00A8, 8'h00, CHK_DIN, 16'h005A, 1'b0);
    add_row("ppi_c_write", OP_IOWR, 16'h00AA, 8'h0F, CHK_PORT_C, 16'h000F, 1'b0);
    add_row("ppi_c_read", OP_IORD, 16'h00AA, 8'h00, CHK_DIN, 16'h000F, 1'b0);
    add_row("ppi_c_set_bit4", OP_IOWR, 16'h00AB, 8'h09, CHK_PORT_C, 16'h001F, 1'b0);
    add_row("ppi_c_clr_bit1", OP_IOWR, 16'h00AB, 8'h02, CHK_PORT_C, 16'h001D, 1'b0);
    add_row("ppi_mode_word", OP_IOWR, 16'h00AB, 8'h8F, CHK_PORT_C, 16'h001D, 1'b0);
    add_row("ppi_b_read", OP_IORD, 16'h00A9, 8'h00, CHK_DIN, {8'h00, i_port_b}, 1'b0);
    add_row("psg_select_14", OP_IOWR, 16'h00A0, 8'd14, CHK_PSG, 16'd14, 1'b0);
    add_row("psg_joy_read", OP_IORD, 16'h00A2, 8'h00, CHK_DIN, {10'd0, ~i_joystick}, 1'b0);
    add_row("psg_select_7", OP_IOWR, 16'h00A0, 8'd7, CHK_PSG, 16'd7, 1'b0);
    // Page 0 sits in slot 2, so nothing answers
    add_row("psg_other_read", OP_IORD, 16'h00A2, 8'h00, CHK_DIN, 16'h0000, 1'b0);

    add_row("vdp_r1_val_a", OP_IOWR, 16'h0099, 8'h18, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r1_mode3", OP_IOWR, 16'h0099, 8'h81, CHK_MODE, 16'd3, 1'b0);
    add_row("vdp_r1_val_b", OP_IOWR, 16'h0099, 8'h10, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r1_mode0", OP_IOWR, 16'h0099, 8'h81, CHK_MODE, 16'd0, 1'b0);
    add_row("vdp_r0_val", OP_IOWR, 16'h0099, 8'h02, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r0_mode2", OP_IOWR, 16'h0099, 8'h80, CHK_MODE, 16'd2, 1'b0);
    add_row("vdp_r1_val_c", OP_IOWR, 16'h0099, 8'h08, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r1_over_r0", OP_IOWR, 16'h0099, 8'h81, CHK_MODE, 16'd3, 1'b0);
    add_row("vdp_r0_clr_val", OP_IOWR, 16'h0099, 8'h00, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r0_clr", OP_IOWR, 16'h0099, 8'h80, CHK_MODE, 16'd3, 1'b0);
    add_row("vdp_r1_clr_val", OP_IOWR, 16'h0099, 8'h00, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_mode1", OP_IOWR, 16'h0099, 8'h81, CHK_MODE, 16'd1, 1'b0);
    add_row("vdp_r9_val", OP_IOWR, 16'h0099, 8'h18, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_r9_ignored", OP_IOWR, 16'h0099, 8'h89, CHK_MODE, 16'd1, 1'b0);

    // Table bases, R2 x 0x400, R3 x 0x40, R4 x 0x800, R5 x 0x80, R6 x 0x800
    add_row("vdp_r2_val", OP_IOWR, 16'h0099, 8'h1B, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_name_base", OP_IOWR, 16'h0099, 8'h82, CHK_NAME, 16'h2C00, 1'b0);
    add_row("vdp_r3_val", OP_IOWR, 16'h0099, 8'hA5, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_color_base", OP_IOWR, 16'h0099, 8'h83, CHK_COLOR, 16'h2940, 1'b0);
    add_row("vdp_r4_val", OP_IOWR, 16'h0099, 8'h05, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_pattern_base", OP_IOWR, 16'h0099, 8'h84, CHK_PATTERN, 16'h2800, 1'b0);
    add_row("vdp_r5_val", OP_IOWR, 16'h0099, 8'h36, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_spr_attr_base", OP_IOWR, 16'h0099, 8'h85, CHK_SPR_ATTR, 16'h1B00, 1'b0);
    add_row("vdp_r6_val", OP_IOWR, 16'h0099, 8'h03, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_spr_pat_base", OP_IOWR, 16'h0099, 8'h86, CHK_SPR_PAT, 16'h1800, 1'b0);
    add_row("vdp_r7_val", OP_IOWR, 16'h0099, 8'hF4, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_colors", OP_IOWR, 16'h0099, 8'h87, CHK_DISP_COL, 16'h00F4, 1'b0);
    add_row("vdp_r1_disp_val", OP_IOWR, 16'h0099, 8'h40, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_display_on", OP_IOWR, 16'h0099, 8'h81, CHK_DISP_COL, 16'h01F4, 1'b0);
    // Graphics 2 keeps only R3 bit 7 and R4 bit 2
    add_row("vdp_r0_g2_val", OP_IOWR, 16'h0099, 8'h02, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_g2_color", OP_IOWR, 16'h0099, 8'h80, CHK_COLOR, 16'h2000, 1'b0);
    add_row("vdp_r4_g2_val", OP_IOWR, 16'h0099, 8'h07, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_g2_pattern", OP_IOWR, 16'h0099, 8'h84, CHK_PATTERN, 16'h2000, 1'b0);
    add_row("vdp_r0_g1_val", OP_IOWR, 16'h0099, 8'h00, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_g1_color", OP_IOWR, 16'h0099, 8'h80, CHK_COLOR, 16'h2940, 1'b0);

    add_row("vdp_addr_lo", OP_IOWR, 16'h0099, 8'h34, CHK_NONE, 16'h0000, 1'b0);
    add_row("vdp_addr_hi", OP_IOWR, 16'h0099, 8'h52, CHK_VADDR, 16'h1234, 1'b0);
    add_row("vdp_data_write", OP_IOWR, 16'h0098, vdp_wdata, CHK_VADDR, 16'h1235, 1'b0);
    add_row("vdp_data_read", OP_IORD, 16'h0098, 8'h00, CHK_DIN, {8'h00, i_vram_dout}, 1'b0);
    add_row("vdp_addr_after_rd", OP_IOWR, 16'h0098, vdp_wdata, CHK_VADDR, 16'h1237, 1'b0);

    add_row("status_flags_in", OP_FLAG, 16'h0000, 8'h03, CHK_NONE, 16'h0000, 1'b0);
    add_row("status_read", OP_IORD, 16'h0099, 8'h00, CHK_DIN, 16'h00BF, 1'b0);
    add_row("status_cleared", OP_IORD, 16'h0099, 8'h00, CHK_DIN, 16'h001F, 1'b0);
    // Fifth sprite 13 reported with too-many set
    add_row("status_5th_in", OP_FLAG, 16'h0000, 8'h6C, CHK_NONE, 16'h0000, 1'b0);
    add_row("status_5th_read", OP_IORD, 16'h0099, 8'h00, CHK_DIN, 16'h004D, 1'b0);

    add_row("slot_map", OP_IOWR, 16'h00A8, 8'h14, CHK_PORT_A, 16'h0014, 1'b0);
    add_row("mem_p1_no_rom", OP_MEMRD, 16'h4000, 8'h00, CHK_DIN, 16'h0000, 1'b0);
    add_row("mem_p1_rom", OP_MEMRD, 16'h4123, 8'h00, CHK_DIN, {8'h00, i_rom_dout}, 1'b1);
    add_row("mem_p2_rom", OP_MEMRD, 16'h8000, 8'h00, CHK_DIN, {8'h00, i_rom_dout}, 1'b0);
    add_row("mem_p0_ram", OP_MEMRD, 16'h0010, 8'h00, CHK_DIN, {8'h00, i_ram_dout}, 1'b0);
    add_row("mem_p3_ram", OP_MEMRD, 16'hC000, 8'h00, CHK_DIN, {8'h00, i_ram_dout}, 1'b0);
    add_row("we_p3_slot0", OP_MEMWR, 16'hC000, 8'hAA, CHK_RAM_WE, 16'd1, 1'b0);
    add_row("we_low_half", OP_MEMWR, 16'h3FFF, 8'hAA, CHK_RAM_WE, 16'd0, 1'b0);
    add_row("we_p2_slot1", OP_MEMWR, 16'h8000, 8'hAA, CHK_RAM_WE, 16'd0, 1'b0);
    add_row("slot_all_zero", OP_IOWR, 16'h00A8, 8'h00, CHK_PORT_A, 16'h0000, 1'b0);
    add_row("we_p2_slot0", OP_MEMWR, 16'h8000, 8'h55, CHK_RAM_WE, 16'd1, 1'b0);
    add_row("mem_p2_ram", OP_MEMRD, 16'h8000, 8'h00, CHK_DIN, {8'h00, i_ram_dout}, 1'b0);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    seed_init          = $urandom(32'h98bc1699);
    cpuClock           = 1'b0;
    n_hard_reset       = 1'b0;
    i_bus              = BUS_IDLE;
    i_port_b           = 8'($urandom());
    i_vram_dout        = 8'($urandom());
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_sprite5          = 5'd0;
    i_joystick         = 6'($urandom()) & 6'h3E;  // Inverted byte never zero
    i_ram_dout         = (8'($urandom()) & 8'h7F) | 8'h01;
    i_rom_dout         = 8'($urandom()) | 8'h80;  // Differs from RAM in bit 7
    i_rom_page1        = 1'b0;
    vdp_wdata          = 8'($urandom());
    build_table();

    repeat (8) @(posedge cpuClock);
    #1;
    n_hard_reset = 1'b1;

    // Enable high three cycles out of seven
    wait_enable(1'b1);
    measure_enable(1'b1, en_high);
    measure_enable(1'b0, en_low);
    check_value("clk_en_high", 16'd3, en_high[15:0]);
    check_value("clk_en_low", 16'd4, en_low[15:0]);

    for (int i = 0; i < rows.size(); i++) begin
      run_row(names[i], rows[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/bus_read_mux.sv ====
`default_nettype none

`include "msx_defines.svh"

module bus_read_mux import msx_pkg::*; (
  input  cpu_bus_t                i_bus,
  input  io_strobe_t              i_strobe,
  input  logic [7:0]              i_port_a,
  input  logic [7:0]              i_port_b,
  input  logic [7:0]              i_port_c,
  input  logic [7:0]              i_vram_dout,
  input  logic [7:0]              i_status,
  input  logic [5:0]              i_joystick,  // Buttons, active low
  input  logic [7:0]              i_ram_dout,
  input  logic [7:0]              i_rom_dout,
  input  logic                    i_rom_page1,
  output logic [7:0]              o_cpu_din,
  output logic                    o_ram_we
);

  logic [1:0] page;
  logic [1:0] page_slot;
  logic [7:0] joy_byte;

  assign page      = i_bus.addr[15:14];
  assign page_slot = i_port_a[{page, 1'b0} +: 2]; // Slot mapped into this page
  assign joy_byte  = {2'b00, ~i_joystick};

  // ============================================================
  // CPU read data, I/O first then memory
  // ============================================================
  always_comb begin
    if (i_strobe.rd_ppi_a)         o_cpu_din = i_port_a;
    else if (i_strobe.rd_ppi_b)    o_cpu_din = i_port_b;
    else if (i_strobe.rd_ppi_c)    o_cpu_din = i_port_c;
    else if (i_strobe.rd_vdp_data) o_cpu_din = i_vram_dout;
    else if (i_strobe.rd_status)   o_cpu_din = i_status;
    else if (i_strobe.rd_joy)      o_cpu_din = joy_byte;
    // Cartridge in slot 1
    else if (i_rom_page1 && page == 2'd1 && i_strobe.mem_rd && i_port_a[3:2] == 2'd1)
      o_cpu_din = i_rom_dout;
    else if (page == 2'd2 && i_strobe.mem_rd && i_port_a[5:4] == 2'd1)
      o_cpu_din = i_rom_dout;
    else if (page_slot == 2'd0)    o_cpu_din = i_ram_dout;
    else                           o_cpu_din = 8'h00;
  end

  // Only the upper 32 KB of slot 0 is writable
  assign o_ram_we = i_bus.addr[15] && page_slot == 2'd0 && i_strobe.mem_wr;

endmodule

`default_nettype wire

// ==== source/io_control.sv ====
`default_nettype none

`include "msx_defines.svh"

module io_control import msx_pkg::*; (
  input  logic       cpuClock,
  input  logic       n_hard_reset,
  input  cpu_bus_t   i_bus,
  output logic       o_cpu_clk_en,
  output io_strobe_t o_strobe,
  output logic [3:0] o_psg_reg
);

  localparam int CNT_W = $clog2(`MSX_CLK_DIV);

  logic [CNT_W-1:0] clk_cnt;
  logic             clk_en_q;
  logic             edge_en;
  logic             io_rd;
  logic             io_wr;
  logic [7:0]       port;
  logic             rd_vdp_data_q;
  logic             rd_status_q;

  // ============================================================
  // CPU clock enable, divide by 7
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      clk_cnt  <= '0;
      clk_en_q <= 1'b0;
    end else begin
      clk_en_q <= o_cpu_clk_en;
      if (clk_cnt == CNT_W'(`MSX_CLK_DIV - 1)) clk_cnt <= '0;
      else clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign o_cpu_clk_en = clk_cnt[CNT_W-1]; // High for counts 4..6
  assign edge_en      = o_cpu_clk_en && !clk_en_q;

  // ============================================================
  // Port decode
  // ============================================================
  assign io_rd = !i_bus.n_rd && !i_bus.n_iorq;
  assign io_wr = !i_bus.n_wr && !i_bus.n_iorq;
  assign port  = i_bus.addr[7:0];

  always_comb begin
    o_strobe.rd_ppi_a    = io_rd && port == `MSX_PPI_A_PORT;
    o_strobe.rd_ppi_b    = io_rd && port == `MSX_PPI_B_PORT;
    o_strobe.rd_ppi_c    = io_rd && port == `MSX_PPI_C_PORT;
    o_strobe.rd_vdp_data = io_rd && port == `MSX_VDP_DATA_PORT;
    o_strobe.rd_status   = io_rd && port == `MSX_VDP_CTRL_PORT;
    o_strobe.rd_joy      = io_rd && port == `MSX_PSG_READ_PORT &&
                           o_psg_reg == 4'(`MSX_PSG_JOY_REG);
    o_strobe.mem_rd      = !i_bus.n_rd && !i_bus.n_mreq;
    o_strobe.mem_wr      = !i_bus.n_wr && !i_bus.n_mreq;

    o_strobe.vdp_data_wr = edge_en && io_wr && port == `MSX_VDP_DATA_PORT;
    o_strobe.vdp_ctrl_wr = edge_en && io_wr && port == `MSX_VDP_CTRL_PORT;
    o_strobe.ppi_a_wr    = edge_en && io_wr && port == `MSX_PPI_A_PORT;
    o_strobe.ppi_c_wr    = edge_en && io_wr && port == `MSX_PPI_C_PORT;
    o_strobe.ppi_bit_wr  = edge_en && io_wr && port == `MSX_PPI_CMD_PORT;

    // End of read, select gone after being seen at the previous edge
    o_strobe.vdp_read_done    = edge_en && rd_vdp_data_q && !o_strobe.rd_vdp_data;
    o_strobe.status_read_done = edge_en && rd_status_q && !o_strobe.rd_status;
  end

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      rd_vdp_data_q <= 1'b0;
      rd_status_q   <= 1'b0;
      o_psg_reg     <= 4'd0;
    end else if (edge_en) begin
      rd_vdp_data_q <= o_strobe.rd_vdp_data;
      rd_status_q   <= o_strobe.rd_status;
      if (io_wr && port == `MSX_PSG_REG_PORT) o_psg_reg <= i_bus.data[3:0];
    end
  end

  // One bus cycle type at a time, I/O selects outrank memory in the read mux
  a_bus_cycle_type: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(!i_bus.n_mreq && !i_bus.n_iorq) && !(!i_bus.n_rd && !i_bus.n_wr));

endmodule

`default_nettype wire

// ==== source/msx_defines.svh ====
`ifndef MSX_DEFINES_SVH
`define MSX_DEFINES_SVH

// ============================================================
// MSX I/O port map
// ============================================================

// VDP ports, read and write share the address
`define MSX_VDP_DATA_PORT 8'h98
`define MSX_VDP_CTRL_PORT 8'h99

// PSG ports
`define MSX_PSG_REG_PORT  8'hA0
`define MSX_PSG_READ_PORT 8'hA2

// PPI 8255 ports
`define MSX_PPI_A_PORT    8'hA8
`define MSX_PPI_B_PORT    8'hA9
`define MSX_PPI_C_PORT    8'hAA
`define MSX_PPI_CMD_PORT  8'hAB

// ============================================================
// Sizes and ratios
// ============================================================

`define MSX_CLK_DIV       7   // cpuClock cycles per CPU enable period
`define MSX_PSG_JOY_REG   14  // PSG register holding the joystick bits
`define MSX_VDP_REG_COUNT 8
`define MSX_VRAM_AW       14  // 16 KB of VRAM

`endif

// ==== source/msx_io.sv ====
`default_nettype none

`include "msx_defines.svh"

module msx_io import msx_pkg::*; (
  input  logic                    cpuClock,
  input  logic                    n_hard_reset,
  input  cpu_bus_t                i_bus,
  input  logic [7:0]              i_port_b,          // Keyboard row data
  input  logic [7:0]              i_vram_dout,
  input  logic                    i_interrupt_flag,
  input  logic                    i_sprite_collision,
  input  logic                    i_too_many_sprites,
  input  logic [4:0]              i_sprite5,
  input  logic [5:0]              i_joystick,
  input  logic [7:0]              i_ram_dout,
  input  logic [7:0]              i_rom_dout,
  input  logic                    i_rom_page1,
  output logic                    o_cpu_clk_en,
  output logic [7:0]              o_cpu_din,
  output logic                    o_ram_we,
  output logic [`MSX_VRAM_AW-1:0] o_vram_addr,
  output logic                    o_vram_wr,
  output vdp_view_t               o_view,
  output logic [1:0]              o_mode,
  output logic [3:0]              o_psg_reg,
  output logic [7:0]              o_port_a,
  output logic [7:0]              o_port_c           // Keyboard row select
);

  io_strobe_t strobe;
  logic [7:0] status;

  io_control u_io_control (
    .cpuClock, .n_hard_reset, .i_bus,
    .o_cpu_clk_en, .o_strobe(strobe), .o_psg_reg
  );

  vdp_port u_vdp_port (
    .cpuClock, .n_hard_reset, .i_strobe(strobe), .i_data(i_bus.data),
    .o_vram_addr, .o_vram_wr, .o_view
  );

  vdp_status u_vdp_status (
    .cpuClock, .n_hard_reset, .i_strobe(strobe),
    .i_interrupt_flag, .i_sprite_collision, .i_too_many_sprites, .i_sprite5,
    .o_status(status)
  );

  ppi_port u_ppi_port (
    .cpuClock, .n_hard_reset, .i_strobe(strobe), .i_data(i_bus.data),
    .o_port_a, .o_port_c
  );

  bus_read_mux u_bus_read_mux (
    .i_bus, .i_strobe(strobe), .i_port_a(o_port_a), .i_port_b, .i_port_c(o_port_c),
    .i_vram_dout, .i_status(status), .i_joystick, .i_ram_dout, .i_rom_dout,
    .i_rom_page1, .o_cpu_din, .o_ram_we
  );

  assign o_mode = o_view.mode;

endmodule

`default_nettype wire

// ==== source/msx_pkg.sv ====
`default_nettype none

`include "msx_defines.svh"

package msx_pkg;

  // Z80 style bus, all controls active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;   // CPU write data
    logic        n_rd;
    logic        n_wr;
    logic        n_mreq;
    logic        n_iorq;
  } cpu_bus_t;

  typedef struct packed {
    // Pulses, one cpuClock cycle on the enable edge
    logic vdp_data_wr;
    logic vdp_ctrl_wr;
    logic vdp_read_done;
    logic status_read_done;
    logic ppi_a_wr;
    logic ppi_c_wr;
    logic ppi_bit_wr;
    // Levels straight from the bus
    logic rd_ppi_a;
    logic rd_ppi_b;
    logic rd_ppi_c;
    logic rd_vdp_data;
    logic rd_status;
    logic rd_joy;
    logic mem_rd;
    logic mem_wr;
  } io_strobe_t;

  // Second VDP control byte, bit 7 picks the meaning
  typedef union packed {
    struct packed {
      logic       is_reg;   // 1 here
      logic       unused;
      logic [5:0] index;
    } reg_wr;
    struct packed {
      logic       is_reg;   // 0 here
      logic       unused;
      logic [5:0] addr_hi;
    } addr_ld;
  } vdp_ctrl_u;

  typedef struct packed {
    logic [1:0]              mode;
    logic                    display_en;
    logic [`MSX_VRAM_AW-1:0] name_base;
    logic [`MSX_VRAM_AW-1:0] color_base;
    logic [`MSX_VRAM_AW-1:0] pattern_base;
    logic [`MSX_VRAM_AW-1:0] sprite_attr_base;
    logic [`MSX_VRAM_AW-1:0] sprite_pattern_base;
    logic [3:0]              text_color;
    logic [3:0]              back_color;
  } vdp_view_t;

endpackage

`default_nettype wire

// ==== source/ppi_port.sv ====
`default_nettype none

module ppi_port import msx_pkg::*; (
  input  logic       cpuClock,
  input  logic       n_hard_reset,
  input  io_strobe_t i_strobe,
  input  logic [7:0] i_data,
  output logic [7:0] o_port_a,
  output logic [7:0] o_port_c
);

  // Port A: slot per 16 KB page, two bits each
  // Port C: keyboard row in the low nibble
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_port_a <= 8'h00; // All pages in slot 0
      o_port_c <= 8'h00;
    end else begin
      if (i_strobe.ppi_a_wr) o_port_a <= i_data;

      if (i_strobe.ppi_c_wr) begin
        o_port_c <= i_data;
      end else if (i_strobe.ppi_bit_wr && !i_data[7]) begin
        // Bit set/reset, bit 7 set would be a mode word
        o_port_c[i_data[3:1]] <= i_data[0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/vdp_port.sv ====
`default_nettype none

`include "msx_defines.svh"

module vdp_port import msx_pkg::*; (
  input  logic                    cpuClock,
  input  logic                    n_hard_reset,
  input  io_strobe_t              i_strobe,
  input  logic [7:0]              i_data,
  output logic [`MSX_VRAM_AW-1:0] o_vram_addr,
  output logic                    o_vram_wr,
  output vdp_view_t               o_view
);

  localparam int IDX_W = $clog2(`MSX_VDP_REG_COUNT);

  logic       second_phase;                       // Next control byte is the second
  logic [7:0] first_byte;
  logic [7:0] vdp_reg [`MSX_VDP_REG_COUNT];
  vdp_ctrl_u  ctrl;

  assign ctrl = i_data;

  // ============================================================
  // Control latch, registers, VRAM pointer
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_phase <= 1'b0;
      o_vram_addr  <= '0;
      for (int i = 0; i < `MSX_VDP_REG_COUNT; i++) vdp_reg[i] <= 8'h00;
    end else begin
      // Pointer steps after each data access
      if (i_strobe.vdp_data_wr || i_strobe.vdp_read_done) o_vram_addr <= o_vram_addr + 1'b1;

      if (i_strobe.vdp_ctrl_wr) begin
        second_phase <= !second_phase;
        if (!second_phase) begin
          first_byte <= i_data;
        end else if (ctrl.reg_wr.is_reg) begin
          if (ctrl.reg_wr.index < `MSX_VDP_REG_COUNT)
            vdp_reg[ctrl.reg_wr.index[IDX_W-1:0]] <= first_byte;
        end else begin
          o_vram_addr <= {ctrl.addr_ld.addr_hi, first_byte};
        end
      end
    end
  end

  assign o_vram_wr = i_strobe.vdp_data_wr; // Written at the pointer before it steps

  // ============================================================
  // Display mode and table bases
  // ============================================================
  always_comb begin
    if (vdp_reg[1][3])      o_view.mode = 2'd3;
    else if (vdp_reg[0][1]) o_view.mode = 2'd2;
    else if (vdp_reg[1][4]) o_view.mode = 2'd0;
    else                    o_view.mode = 2'd1;

    o_view.display_en = vdp_reg[1][6];
    o_view.name_base  = {vdp_reg[2][3:0], 10'd0};
    if (o_view.mode == 2'd2) begin                // Graphics 2 uses one bit per table
      o_view.color_base   = {vdp_reg[3][7], 13'd0};
      o_view.pattern_base = {vdp_reg[4][2], 13'd0};
    end else begin
      o_view.color_base   = {vdp_reg[3], 6'd0};
      o_view.pattern_base = {vdp_reg[4][2:0], 11'd0};
    end
    o_view.sprite_attr_base    = {vdp_reg[5][6:0], 7'd0};
    o_view.sprite_pattern_base = {vdp_reg[6][2:0], 11'd0};
    o_view.text_color          = vdp_reg[7][7:4];
    o_view.back_color          = vdp_reg[7][3:0];
  end

  // Pointer steps once per cycle, two data accesses must not end together
  a_one_pointer_step: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(i_strobe.vdp_read_done && i_strobe.vdp_data_wr));

endmodule

`default_nettype wire

// ==== source/vdp_status.sv ====
`default_nettype none

module vdp_status import msx_pkg::*; (
  input  logic       cpuClock,
  input  logic       n_hard_reset,
  input  io_strobe_t i_strobe,
  input  logic       i_interrupt_flag,
  input  logic       i_sprite_collision,
  input  logic       i_too_many_sprites,
  input  logic [4:0] i_sprite5,
  output logic [7:0] o_status
);

  logic int_flag;
  logic coll_flag;

  // Sticky until the CPU finishes reading status
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      int_flag  <= 1'b0;
      coll_flag <= 1'b0;
    end else begin
      if (i_interrupt_flag)   int_flag  <= 1'b1;
      if (i_sprite_collision) coll_flag <= 1'b1;
      if (i_strobe.status_read_done) begin // Clear wins over a new set
        int_flag  <= 1'b0;
        coll_flag <= 1'b0;
      end
    end
  end

  assign o_status = {int_flag, i_too_many_sprites, coll_flag,
                     i_too_many_sprites ? i_sprite5 : 5'b11111};

endmodule

`default_nettype wire
